/* source/fabricPkg.sv */
`default_nettype none

package fabricPkg;

    // ------------------------------------------------------------
    // Bus types
    // ------------------------------------------------------------
    typedef logic [31:0] busData_t;
    typedef logic [3:0]  byteStb_t;
    typedef logic [7:0]  gpio_t;
    typedef logic [3:0]  regionId_t;

    // Address seen as region / word / byte, or as one flat byte address
    typedef struct packed {
        regionId_t   region;
        logic [10:0] wordOff;
        logic [1:0]  byteSel;
    } busAddrFields_t;

    typedef union packed {
        logic [16:0]    flat;
        busAddrFields_t fields;
    } busAddr_t;

    // ------------------------------------------------------------
    // Memory map, 8 KB regions
    // ------------------------------------------------------------
    localparam regionId_t REGION_REGS     = 4'd0;
    localparam regionId_t REGION_RAM      = 4'd1;
    localparam regionId_t REGION_RESERVED = 4'd6;

    // Register bank word offsets
    localparam logic [4:0] REG_ID       = 5'h0;
    localparam logic [4:0] REG_REV      = 5'h1;
    localparam logic [4:0] REG_GPIO_IN  = 5'h2;
    localparam logic [4:0] REG_GPIO_OUT = 5'h3;
    localparam logic [4:0] REG_GPIO_OE  = 5'h4;

    // Reserved block word offsets
    localparam logic [6:0] RSV_CUST_PROD = 7'h7E;
    localparam logic [6:0] RSV_REVISIONS = 7'h7F;

    // Identification values
    localparam busData_t    FABRIC_ID_VALUE  = 32'hFAB1_0001;
    localparam busData_t    FABRIC_REV_VALUE = 32'h0000_0100;
    localparam logic [7:0]  RSV_CUSTOMER_ID  = 8'h01;
    localparam logic [7:0]  RSV_PRODUCT_ID   = 8'h00;
    localparam logic [15:0] RSV_MAJOR_REV    = 16'h0001;
    localparam logic [15:0] RSV_MINOR_REV    = 16'h0000;

    // Fill patterns, one per kind of bad access
    localparam busData_t REG_FILL_VALUE   = 32'hFABDEFAC;
    localparam busData_t RSV_FILL_VALUE   = 32'hDEFFABAC;
    localparam busData_t BAD_ACCESS_VALUE = 32'hBADFABAC;

    localparam int TIMEOUT_CYCLES = 7;
    localparam int TIMEOUT_WIDTH  = 3;

    localparam int RAM_DEPTH      = 256;
    localparam int RAM_ADDR_WIDTH = 8;

endpackage

`default_nettype wire

/* source/busDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module busDecoder
(
    input  wire                  wbClk_i,
    input  wire                  rst_i,
    input  wire fabricPkg::busAddr_t wbAdr_i,
    input  wire                  wbCyc_i,
    input  wire                  wbStb_i,

    input  wire                  regAck_i,
    input  wire fabricPkg::busData_t regDat_i,
    input  wire                  ramAck_i,
    input  wire fabricPkg::busData_t ramDat_i,
    input  wire                  rsvAck_i,
    input  wire fabricPkg::busData_t rsvDat_i,

    output logic                 regSel_o,
    output logic                 ramSel_o,
    output logic                 rsvSel_o,
    output logic                 wbAck_o,
    output fabricPkg::busData_t  wbRdDat_o
);

    import fabricPkg::*;

    regionId_t                region;
    logic                     access;
    logic                     undecoded;
    logic                     timeoutAck;
    logic [TIMEOUT_WIDTH-1:0] timeoutCnt;

    // ------------------------------------------------------------
    // Region decode
    // ------------------------------------------------------------
    assign region = wbAdr_i.fields.region;
    assign access = wbCyc_i & wbStb_i;

    assign regSel_o  = access & (region == REGION_REGS);
    assign ramSel_o  = access & (region == REGION_RAM);
    assign rsvSel_o  = access & (region == REGION_RESERVED);
    assign undecoded = access & ~(regSel_o | ramSel_o | rsvSel_o);

    // ------------------------------------------------------------
    // Timeout for undecoded regions
    // ------------------------------------------------------------
    // Ack lands TIMEOUT_CYCLES cycles after the strobe rises
    always_ff @(posedge wbClk_i)
    begin
        if (rst_i)
        begin
            timeoutCnt <= '0;
            timeoutAck <= 1'b0;
        end
        else if (undecoded && !timeoutAck)
        begin
            if (timeoutCnt == TIMEOUT_WIDTH'(TIMEOUT_CYCLES - 1))
            begin
                timeoutCnt <= '0;
                timeoutAck <= 1'b1;
            end
            else
            begin
                timeoutCnt <= timeoutCnt + 1'b1;
            end
        end
        else
        begin
            // Idle, or the ack cycle itself
            timeoutCnt <= '0;
            timeoutAck <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Acknowledge and read data merge
    // ------------------------------------------------------------
    assign wbAck_o = regAck_i | ramAck_i | rsvAck_i | timeoutAck;

    always_comb
    begin
        case (region)
            REGION_REGS:     wbRdDat_o = regDat_i;
            REGION_RAM:      wbRdDat_o = ramDat_i;
            REGION_RESERVED: wbRdDat_o = rsvDat_i;
            default:         wbRdDat_o = BAD_ACCESS_VALUE;
        endcase
    end

endmodule

`default_nettype wire

/* source/fabricRegisters.sv */
`timescale 1ns/1ps
`default_nettype none

module fabricRegisters
(
    input  wire                  wbClk_i,
    input  wire                  rst_i,
    input  wire                  sel_i,
    input  wire                  we_i,
    input  wire [4:0]            wordOff_i,
    input  wire fabricPkg::byteStb_t byteStb_i,
    input  wire fabricPkg::busData_t wrDat_i,
    input  wire fabricPkg::gpio_t    gpioIn_i,

    output logic                 ack_o,
    output fabricPkg::busData_t  rdDat_o,
    output fabricPkg::gpio_t     gpioOut_o,
    output fabricPkg::gpio_t     gpioOe_o
);

    import fabricPkg::*;

    gpio_t gpioMeta;
    gpio_t gpioSync;
    logic  access;
    logic  lane0Write;

    // One access per select, the ack cycle does not repeat it
    assign access     = sel_i & ~ack_o;
    assign lane0Write = access & we_i & byteStb_i[0];

    // ------------------------------------------------------------
    // Ack and GPIO control registers
    // ------------------------------------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (rst_i)
        begin
            ack_o     <= 1'b0;
            gpioOut_o <= '0;
            gpioOe_o  <= '0;
        end
        else
        begin
            ack_o <= access;
            if (lane0Write && (wordOff_i == REG_GPIO_OUT))
            begin
                gpioOut_o <= wrDat_i[7:0];
            end
            if (lane0Write && (wordOff_i == REG_GPIO_OE))
            begin
                gpioOe_o <= wrDat_i[7:0];
            end
        end
    end

    // Two-stage input synchronizer
    always_ff @(posedge wbClk_i)
    begin
        gpioMeta <= gpioIn_i;
        gpioSync <= gpioMeta;
    end

    // ------------------------------------------------------------
    // Registered read data
    // ------------------------------------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (access)
        begin
            case (wordOff_i)
                REG_ID:       rdDat_o <= FABRIC_ID_VALUE;
                REG_REV:      rdDat_o <= FABRIC_REV_VALUE;
                REG_GPIO_IN:  rdDat_o <= {24'h0, gpioSync};
                REG_GPIO_OUT: rdDat_o <= {24'h0, gpioOut_o};
                REG_GPIO_OE:  rdDat_o <= {24'h0, gpioOe_o};
                default:      rdDat_o <= REG_FILL_VALUE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/dataRam.sv */
`timescale 1ns/1ps
`default_nettype none

module dataRam
(
    input  wire                  wbClk_i,
    input  wire                  rst_i,
    input  wire                  sel_i,
    input  wire                  we_i,
    input  wire [fabricPkg::RAM_ADDR_WIDTH-1:0] wordOff_i,
    input  wire fabricPkg::byteStb_t byteStb_i,
    input  wire fabricPkg::busData_t wrDat_i,

    output logic                 ack_o,
    output fabricPkg::busData_t  rdDat_o
);

    import fabricPkg::*;

    busData_t mem [RAM_DEPTH];
    logic     access;

    assign access = sel_i & ~ack_o;

    always_ff @(posedge wbClk_i)
    begin
        if (rst_i)
        begin
            ack_o <= 1'b0;
        end
        else
        begin
            ack_o <= access;
        end
    end

    // ------------------------------------------------------------
    // Storage with byte lanes
    // ------------------------------------------------------------
    always_ff @(posedge wbClk_i)
    begin
        if (access && we_i)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (byteStb_i[lane])
                begin
                    mem[wordOff_i][lane*8 +: 8] <= wrDat_i[lane*8 +: 8];
                end
            end
        end
    end

    // Registered read, gives the one cycle ack latency
    always_ff @(posedge wbClk_i)
    begin
        if (access)
        begin
            rdDat_o <= mem[wordOff_i];
        end
    end

endmodule

`default_nettype wire

/* source/reservedRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module reservedRegs
(
    input  wire                 wbClk_i,
    input  wire                 rst_i,
    input  wire                 sel_i,
    input  wire [6:0]           wordOff_i,

    output logic                ack_o,
    output fabricPkg::busData_t rdDat_o
);

    import fabricPkg::*;

    logic access;

    // Writes are acked like reads and have no effect
    assign access = sel_i & ~ack_o;

    always_ff @(posedge wbClk_i)
    begin
        if (rst_i)
        begin
            ack_o <= 1'b0;
        end
        else
        begin
            ack_o <= access;
        end
    end

    always_ff @(posedge wbClk_i)
    begin
        if (access)
        begin
            case (wordOff_i)
                RSV_CUST_PROD: rdDat_o <= {RSV_CUSTOMER_ID, RSV_PRODUCT_ID, 16'h0};
                RSV_REVISIONS: rdDat_o <= {RSV_MAJOR_REV, RSV_MINOR_REV};
                default:       rdDat_o <= RSV_FILL_VALUE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/fabricTop.sv */
`timescale 1ns/1ps
`default_nettype none

module fabricTop
(
    input  wire                  wbClk_i,
    input  wire                  rst_i,
    input  wire fabricPkg::busAddr_t wbAdr_i,
    input  wire                  wbCyc_i,
    input  wire                  wbStb_i,
    input  wire                  wbWe_i,
    input  wire fabricPkg::byteStb_t wbByteStb_i,
    input  wire fabricPkg::busData_t wbWrDat_i,
    input  wire fabricPkg::gpio_t    gpioIn_i,

    output fabricPkg::busData_t  wbRdDat_o,
    output logic                 wbAck_o,
    output fabricPkg::gpio_t     gpioOut_o,
    output fabricPkg::gpio_t     gpioOe_o
);

    import fabricPkg::*;

    logic     regSel;
    logic     ramSel;
    logic     rsvSel;
    logic     regAck;
    logic     ramAck;
    logic     rsvAck;
    busData_t regDat;
    busData_t ramDat;
    busData_t rsvDat;

    // ------------------------------------------------------------
    // Decoder
    // ------------------------------------------------------------
    busDecoder uDecoder
    (
        .wbClk_i   (wbClk_i),
        .rst_i     (rst_i),
        .wbAdr_i   (wbAdr_i),
        .wbCyc_i   (wbCyc_i),
        .wbStb_i   (wbStb_i),
        .regAck_i  (regAck),
        .regDat_i  (regDat),
        .ramAck_i  (ramAck),
        .ramDat_i  (ramDat),
        .rsvAck_i  (rsvAck),
        .rsvDat_i  (rsvDat),
        .regSel_o  (regSel),
        .ramSel_o  (ramSel),
        .rsvSel_o  (rsvSel),
        .wbAck_o   (wbAck_o),
        .wbRdDat_o (wbRdDat_o)
    );

    // ------------------------------------------------------------
    // Targets
    // ------------------------------------------------------------
    fabricRegisters uRegisters
    (
        .wbClk_i   (wbClk_i),
        .rst_i     (rst_i),
        .sel_i     (regSel),
        .we_i      (wbWe_i),
        .wordOff_i (wbAdr_i.fields.wordOff[4:0]),
        .byteStb_i (wbByteStb_i),
        .wrDat_i   (wbWrDat_i),
        .gpioIn_i  (gpioIn_i),
        .ack_o     (regAck),
        .rdDat_o   (regDat),
        .gpioOut_o (gpioOut_o),
        .gpioOe_o  (gpioOe_o)
    );

    // Upper word offset bits alias onto the 256 words
    dataRam uDataRam
    (
        .wbClk_i   (wbClk_i),
        .rst_i     (rst_i),
        .sel_i     (ramSel),
        .we_i      (wbWe_i),
        .wordOff_i (wbAdr_i.fields.wordOff[RAM_ADDR_WIDTH-1:0]),
        .byteStb_i (wbByteStb_i),
        .wrDat_i   (wbWrDat_i),
        .ack_o     (ramAck),
        .rdDat_o   (ramDat)
    );

    reservedRegs uReserved
    (
        .wbClk_i   (wbClk_i),
        .rst_i     (rst_i),
        .sel_i     (rsvSel),
        .wordOff_i (wbAdr_i.fields.wordOff[6:0]),
        .ack_o     (rsvAck),
        .rdDat_o   (rsvDat)
    );

endmodule

`default_nettype wire

/* include/tbChecks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ------------------------------------------------------------
// Compare tasks
// ------------------------------------------------------------
task automatic checkData(input string name, input busData_t got, input busData_t exp);
    checkCount++;
    if (got !== exp)
    begin
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
        errorCount++;
    end
endtask

task automatic checkGpio(input string name, input gpio_t got, input gpio_t exp);
    checkCount++;
    if (got !== exp)
    begin
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
        errorCount++;
    end
endtask

task automatic checkFlag(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp)
    begin
        $display("Mismatch %s: got %h, expected %h", name, got, exp);
        errorCount++;
    end
endtask

// ------------------------------------------------------------
// Address helpers and reference model
// ------------------------------------------------------------
function automatic busAddr_t makeAddr(input regionId_t region, input logic [10:0] wordOff);
    busAddr_t adr;
    adr.fields.region  = region;
    adr.fields.wordOff = wordOff;
    adr.fields.byteSel = 2'b00;
    return adr;
endfunction

// Decoded targets ack after one cycle, anything else after the timeout
function automatic int expectedLatency(input busAddr_t adr);
    case (adr.fields.region)
        REGION_REGS, REGION_RAM, REGION_RESERVED: return 1;
        default:                                  return TIMEOUT_CYCLES;
    endcase
endfunction

function automatic busData_t expectedRead(input busAddr_t adr);
    logic [10:0] word;
    busData_t    value;
    word = adr.fields.wordOff;
    case (adr.fields.region)
        REGION_REGS:
        begin
            case (word[4:0])
                REG_ID:       value = FABRIC_ID_VALUE;
                REG_REV:      value = FABRIC_REV_VALUE;
                REG_GPIO_IN:  value = {24'h0, gpioInModel};
                REG_GPIO_OUT: value = {24'h0, gpioOutModel};
                REG_GPIO_OE:  value = {24'h0, gpioOeModel};
                default:      value = REG_FILL_VALUE;
            endcase
        end
        // Only the low eight word bits reach the RAM
        REGION_RAM:      value = ramModel[word[7:0]];
        REGION_RESERVED:
        begin
            case (word[6:0])
                RSV_CUST_PROD: value = {RSV_CUSTOMER_ID, RSV_PRODUCT_ID, 16'h0};
                RSV_REVISIONS: value = {RSV_MAJOR_REV, RSV_MINOR_REV};
                default:       value = RSV_FILL_VALUE;
            endcase
        end
        default:         value = BAD_ACCESS_VALUE;
    endcase
    return value;
endfunction

function automatic void modelWrite(input busAddr_t adr, input byteStb_t bs, input busData_t data);
    logic [10:0] word;
    word = adr.fields.wordOff;
    if (adr.fields.region == REGION_REGS && bs[0])
    begin
        if (word[4:0] == REG_GPIO_OUT)
        begin
            gpioOutModel = data[7:0];
        end
        if (word[4:0] == REG_GPIO_OE)
        begin
            gpioOeModel = data[7:0];
        end
    end
    else if (adr.fields.region == REGION_RAM)
    begin
        for (int lane = 0; lane < 4; lane++)
        begin
            if (bs[lane])
            begin
                ramModel[word[7:0]][lane*8 +: 8] = data[lane*8 +: 8];
            end
        end
    end
endfunction

// ------------------------------------------------------------
// Bus tasks called on a falling edge
// ------------------------------------------------------------
task automatic busAccess(input busAddr_t adr, input logic we, input byteStb_t bs,
                         input busData_t wdat, output busData_t rdat);
    int   latency;
    int   expLatency;
    logic acked;
    latency    = 0;
    acked      = 1'b0;
    rdat       = '0;
    expLatency = expectedLatency(adr);
    wbAdr_i     = adr;
    wbWe_i      = we;
    wbByteStb_i = bs;
    wbWrDat_i   = wdat;
    wbCyc_i     = 1'b1;
    wbStb_i     = 1'b1;
    while (!acked && latency < ACK_WAIT_LIMIT)
    begin
        @(negedge wbClk_i);
        latency++;
        if (wbAck_o)
        begin
            acked = 1'b1;
            rdat  = wbRdDat_o;
        end
    end
    // Strobe stays up through the ack cycle and drops in the cycle after
    if (acked)
    begin
        @(negedge wbClk_i);
        if (wbAck_o)
        begin
            $display("Ack from address %h stayed high for more than one cycle", adr.flat);
            errorCount++;
        end
    end
    wbCyc_i = 1'b0;
    wbStb_i = 1'b0;
    wbWe_i  = 1'b0;
    if (!acked)
    begin
        $display("No acknowledge from address %h within %0d cycles", adr.flat, ACK_WAIT_LIMIT);
        errorCount++;
    end
    else if (latency != expLatency)
    begin
        $display("Ack from address %h came %0d cycles after the strobe, expected %0d",
                 adr.flat, latency, expLatency);
        errorCount++;
    end
    @(negedge wbClk_i);
endtask

task automatic busRead(input busAddr_t adr, output busData_t rdat);
    busAccess(adr, 1'b0, 4'hF, '0, rdat);
endtask

task automatic writeAndModel(input busAddr_t adr, input byteStb_t bs, input busData_t data);
    busData_t unused;
    busAccess(adr, 1'b1, bs, data, unused);
    modelWrite(adr, bs, data);
endtask

task automatic readAndCheck(input busAddr_t adr);
    busData_t got;
    busRead(adr, got);
    checkData($sformatf("wbRdDat_o[%05h]", adr.flat), got, expectedRead(adr));
endtask

`endif

/* dv/tbTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tbTop;

    import fabricPkg::*;

    localparam int          RESET_CYCLES    = 5;
    localparam int          ACK_WAIT_LIMIT  = 2 * TIMEOUT_CYCLES + 4;
    localparam int          ACCESS_ESTIMATE = 140;
    localparam int          CYCLE_LIMIT     = 2 * (RESET_CYCLES + 20 +
                                                   ACCESS_ESTIMATE * (TIMEOUT_CYCLES + 2));
    localparam logic [31:0] RANDOM_SEED     = 32'h86c7_2268;

    logic     wbClk_i;
    logic     rst_i;
    busAddr_t wbAdr_i;
    logic     wbCyc_i;
    logic     wbStb_i;
    logic     wbWe_i;
    byteStb_t wbByteStb_i;
    busData_t wbWrDat_i;
    gpio_t    gpioIn_i;
    busData_t wbRdDat_o;
    logic     wbAck_o;
    gpio_t    gpioOut_o;
    gpio_t    gpioOe_o;

    // Reference state
    busData_t ramModel [RAM_DEPTH];
    gpio_t    gpioOutModel;
    gpio_t    gpioOeModel;
    gpio_t    gpioInModel;

    int errorCount;
    int checkCount;
    int testCount;
    int testStartErrors;
    int cycleCount;

    `include "tbChecks.svh"

    fabricTop dut
    (
        .wbClk_i     (wbClk_i),
        .rst_i       (rst_i),
        .wbAdr_i     (wbAdr_i),
        .wbCyc_i     (wbCyc_i),
        .wbStb_i     (wbStb_i),
        .wbWe_i      (wbWe_i),
        .wbByteStb_i (wbByteStb_i),
        .wbWrDat_i   (wbWrDat_i),
        .gpioIn_i    (gpioIn_i),
        .wbRdDat_o   (wbRdDat_o),
        .wbAck_o     (wbAck_o),
        .gpioOut_o   (gpioOut_o),
        .gpioOe_o    (gpioOe_o)
    );

    always #2 wbClk_i = ~wbClk_i;

    // Run limit
    always @(posedge wbClk_i)
    begin
        cycleCount++;
        if (cycleCount > CYCLE_LIMIT)
        begin
            $display("Run stopped after %0d cycles without finishing", cycleCount);
            $display("Errors found");
            $finish;
        end
    end

    task automatic finishTest(input string name);
        testCount++;
        $display("Test %0d %s: %s, %0d errors", testCount, name,
                 (errorCount == testStartErrors) ? "passed" : "failed",
                 errorCount - testStartErrors);
        testStartErrors = errorCount;
    endtask

    initial
    begin
        busData_t   value;
        busData_t   got;
        logic [7:0] ramOffsets [32];
        logic [7:0] swapOffset;
        int         pick;

        wbClk_i      = 1'b0;
        rst_i        = 1'b1;
        wbAdr_i      = '0;
        wbCyc_i      = 1'b0;
        wbStb_i      = 1'b0;
        wbWe_i       = 1'b0;
        wbByteStb_i  = '0;
        wbWrDat_i    = '0;
        gpioIn_i     = '0;
        gpioOutModel = '0;
        gpioOeModel  = '0;
        gpioInModel  = '0;
        errorCount      = 0;
        checkCount      = 0;
        testCount       = 0;
        testStartErrors = 0;
        cycleCount      = 0;
        void'($urandom(RANDOM_SEED));

        repeat (RESET_CYCLES) @(negedge wbClk_i);
        rst_i = 1'b0;

        // ------------------------------------------------------------
        // Reset values and ID words
        // ------------------------------------------------------------
        checkGpio("gpioOut_o", gpioOut_o, 8'h00);
        checkGpio("gpioOe_o", gpioOe_o, 8'h00);
        checkFlag("wbAck_o", wbAck_o, 1'b0);
        readAndCheck(makeAddr(REGION_REGS, 11'(REG_ID)));
        readAndCheck(makeAddr(REGION_REGS, 11'(REG_REV)));
        readAndCheck(makeAddr(REGION_REGS, 11'd9));
        finishTest("reset and ID");

        // ------------------------------------------------------------
        // GPIO
        // ------------------------------------------------------------
        for (int i = 0; i < 4; i++)
        begin
            writeAndModel(makeAddr(REGION_REGS, 11'(REG_GPIO_OUT)), 4'hF, $urandom);
            writeAndModel(makeAddr(REGION_REGS, 11'(REG_GPIO_OE)), 4'hF, $urandom);
            checkGpio("gpioOut_o", gpioOut_o, gpioOutModel);
            checkGpio("gpioOe_o", gpioOe_o, gpioOeModel);
            readAndCheck(makeAddr(REGION_REGS, 11'(REG_GPIO_OUT)));
            readAndCheck(makeAddr(REGION_REGS, 11'(REG_GPIO_OE)));
        end
        // Lane 0 off, both registers keep their value
        writeAndModel(makeAddr(REGION_REGS, 11'(REG_GPIO_OUT)), 4'b1110, $urandom);
        writeAndModel(makeAddr(REGION_REGS, 11'(REG_GPIO_OE)), 4'b1110, $urandom);
        checkGpio("gpioOut_o", gpioOut_o, gpioOutModel);
        checkGpio("gpioOe_o", gpioOe_o, gpioOeModel);
        for (int i = 0; i < 4; i++)
        begin
            gpioIn_i    = 8'($urandom);
            gpioInModel = gpioIn_i;
            repeat (3) @(negedge wbClk_i);
            readAndCheck(makeAddr(REGION_REGS, 11'(REG_GPIO_IN)));
        end
        finishTest("GPIO");

        // ------------------------------------------------------------
        // RAM, distinct words with aliased upper offset bits
        // ------------------------------------------------------------
        for (int i = 0; i < 32; i++)
        begin
            ramOffsets[i] = 8'(i * 8) + 8'($urandom % 8);
            writeAndModel(makeAddr(REGION_RAM, {3'($urandom), ramOffsets[i]}), 4'hF, $urandom);
            if (i % 3 == 0)
            begin
                writeAndModel(makeAddr(REGION_RAM, {3'($urandom), ramOffsets[i]}),
                              4'($urandom), $urandom);
            end
        end
        for (int i = 31; i > 0; i--)
        begin
            pick             = int'($urandom % (i + 1));
            swapOffset       = ramOffsets[i];
            ramOffsets[i]    = ramOffsets[pick];
            ramOffsets[pick] = swapOffset;
        end
        for (int i = 0; i < 32; i++)
        begin
            readAndCheck(makeAddr(REGION_RAM, {3'($urandom), ramOffsets[i]}));
        end
        finishTest("RAM");

        // ------------------------------------------------------------
        // Reserved block
        // ------------------------------------------------------------
        busRead(makeAddr(REGION_RESERVED, 11'(RSV_CUST_PROD)), got);
        checkData("wbRdDat_o", got, 32'h0100_0000);
        busRead(makeAddr(REGION_RESERVED, 11'(RSV_REVISIONS)), got);
        checkData("wbRdDat_o", got, 32'h0001_0000);
        readAndCheck(makeAddr(REGION_RESERVED, 11'd10));
        finishTest("reserved block");

        // ------------------------------------------------------------
        // Undecoded regions
        // ------------------------------------------------------------
        readAndCheck(makeAddr(4'd3, 11'd0));
        value = ~{24'h0, gpioOutModel};
        writeAndModel(makeAddr(4'd3, 11'(REG_GPIO_OUT)), 4'hF, value);
        writeAndModel(makeAddr(4'd3, {3'b000, ramOffsets[0]}), 4'hF, $urandom);
        checkGpio("gpioOut_o", gpioOut_o, gpioOutModel);
        readAndCheck(makeAddr(REGION_REGS, 11'(REG_GPIO_OUT)));
        readAndCheck(makeAddr(REGION_RAM, {3'b000, ramOffsets[0]}));
        readAndCheck(makeAddr(4'd15, 11'h7FF));
        finishTest("undecoded region");

        // ------------------------------------------------------------
        // Ack timing on every target, reads and writes
        // ------------------------------------------------------------
        writeAndModel(makeAddr(REGION_REGS, 11'(REG_GPIO_OE)), 4'h1, $urandom);
        readAndCheck(makeAddr(REGION_REGS, 11'(REG_GPIO_OE)));
        writeAndModel(makeAddr(REGION_RAM, {3'b000, ramOffsets[1]}), 4'b0110, $urandom);
        readAndCheck(makeAddr(REGION_RAM, {3'b000, ramOffsets[1]}));
        writeAndModel(makeAddr(REGION_RESERVED, 11'(RSV_REVISIONS)), 4'hF, $urandom);
        readAndCheck(makeAddr(REGION_RESERVED, 11'(RSV_REVISIONS)));
        finishTest("ack timing");

        $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("No errors");
        end
        else
        begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
source/fabricPkg.sv
source/busDecoder.sv
source/fabricRegisters.sv
source/dataRam.sv
source/reservedRegs.sv
source/fabricTop.sv
dv/tbTop.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tbTop -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/VtbTop)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1
